// ==== vlog.f ====
+incdir+verification
verilog/audio_format_pkg.sv
verilog/audio_control_pkg.sv
verilog/audio_source_sync.sv
verilog/audio_mix_stage.sv
verilog/audio_compressor.sv
verilog/pcxt_audio_top.sv
verification/tb_pcxt_audio.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_pcxt_audio
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_pcxt_audio_tests.svh ====
// Directed test tasks for the audio path, included into the testbench module body

//////////////////////////////////////////////////////////////////////
// Reset and silence
//////////////////////////////////////////////////////////////////////

// Reset is high from time zero until after the second edge
task automatic reset_state_test();
	@(posedge clk_chipset);
	#SAMPLE_DELAY;
	check_sample(audio_left, '0, "output in first reset cycle");
	check_pair(audio_left, audio_right);
	drive_slot();
	check_sample(audio_left, '0, "output in second reset cycle");
	reset_wire = 1'b0;
	hold_output('0, 6, "output after reset");
endtask

// Silence all sources and settle without timing
task automatic quiet_sources();
	drive_slot();
	opl_sample_in   = '0;
	tandy_sample_in = '0;
	tandy_volume    = '0;
	speaker_bit     = 1'b1;
	speaker_volume  = '0;
	await_output(current_expected(), 0, "silent sources");
endtask

//////////////////////////////////////////////////////////////////////
// Capture filter and source scaling
//////////////////////////////////////////////////////////////////////

task automatic stability_filter_test();
	logic [OPL_W-1:0]    value;
	logic [SAMPLE_W-1:0] stable;
	int                  step;
	for (step = 0; step < 6; step++) begin
		value = random_word();
		if (value == opl_sample_in) begin
			value = ~value;
		end
		drive_slot();
		opl_sample_in = value;
		await_output(current_expected(), 5, "FM sample after stable hold");
	end
	// New value every cycle so two reads never agree
	stable = current_expected();
	for (step = 0; step < 8; step++) begin
		value = random_word();
		if (value == opl_sample_in) begin
			value = value ^ 16'h0001;
		end
		drive_slot();
		opl_sample_in = value;
		#(SAMPLE_DELAY - DRIVE_DELAY);
		check_sample(audio_left, stable, "output while FM input keeps changing");
	end
	await_output(current_expected(), 5, "FM sample once input settles");
endtask

task automatic volume_sum_test();
	logic [15:0] word;
	int          vol;
	drive_slot();
	opl_sample_in = 16'd1200;
	await_output(current_expected(), 5, "FM base for volume test");
	for (vol = 0; vol < 4; vol++) begin
		word = random_word();
		drive_slot();
		tandy_sample_in = word[TANDY_W-1:0];
		tandy_volume = vol[VOLUME_W-1:0];
		await_output(current_expected(), 5, "Tandy level with volume shift");
	end
	// Speaker is active low
	for (vol = 0; vol < 4; vol++) begin
		drive_slot();
		speaker_bit = 1'b0;
		speaker_volume = vol[VOLUME_W-1:0];
		await_output(current_expected(), 3, "speaker level with volume shift");
	end
	drive_slot();
	speaker_bit = 1'b1;
	await_output(current_expected(), 3, "speaker released");
endtask

task automatic saturation_test();
	quiet_sources();
	drive_slot();
	speaker_bit = 1'b0;
	speaker_volume = 2'd3;
	await_output(current_expected(), 3, "loud speaker");
	drive_slot();
	tandy_sample_in = 14'h1000;
	tandy_volume = 2'd1;
	await_output(current_expected(), 5, "Tandy toward positive overflow");
	drive_slot();
	opl_sample_in = 16'd30000;
	await_output(current_expected(), 5, "FM toward positive overflow");
	check_sample(audio_left, 16'h7FFF, "positive full scale");
	// Tandy word 0xC000 reads as a negative level short of full scale
	quiet_sources();
	drive_slot();
	tandy_sample_in = 14'h3000;
	tandy_volume = 2'd2;
	await_output(current_expected(), 5, "Tandy toward negative overflow");
	drive_slot();
	opl_sample_in = 16'h8000;
	await_output(current_expected(), 5, "FM toward negative overflow");
	check_sample(audio_left, 16'h8000, "negative full scale");
endtask

//////////////////////////////////////////////////////////////////////
// Compressor
//////////////////////////////////////////////////////////////////////

// Threshold edges for both signs and random mixes within the curve range
task automatic run_curve(input logic [BOOST_W-1:0] mode, input int thresh, input string name);
	logic [SAMPLE_W-1:0] vectors[$];
	logic [31:0]         word;
	int                  idx;
	vectors.push_back(16'(thresh - 1));
	vectors.push_back(16'(thresh));
	vectors.push_back(16'(1 - thresh));
	vectors.push_back(16'(-thresh));
	for (idx = 0; idx < 8; idx++) begin
		word = lcg_next();
		vectors.push_back(16'((word % 32'd64001) - 32'd32000));
	end
	drive_slot();
	boost_mode = mode;
	await_output(current_expected(), 1, {name, " curve selected"});
	for (idx = 0; idx < vectors.size(); idx++) begin
		drive_slot();
		opl_sample_in = vectors[idx];
		await_output(current_expected(), 6, {name, " curve result"});
	end
endtask

task automatic compressor_curve_test();
	quiet_sources();
	run_curve(BOOST_2X, curve_threshold(LOW_RATIO, LOW_GAIN), "low");
	run_curve(BOOST_4X, curve_threshold(HIGH_RATIO, HIGH_GAIN), "high");
	// Code 3 lands on the high curve
	drive_slot();
	boost_mode = 2'd3;
	await_output(current_expected(), 1, "boost code 3");
	// Bypass is combinational
	drive_slot();
	boost_mode = BOOST_OFF;
	#(SAMPLE_DELAY - DRIVE_DELAY);
	check_sample(audio_left, current_expected(), "plain mix after boost off");
	hold_output(current_expected(), HOLD_CYCLES, "plain mix after boost off");
endtask

// ==== verification/tb_pcxt_audio.sv ====
// Testbench for the audio path top level, run as the simulation top with the included test tasks
`timescale 1ns/1ps

module tb_pcxt_audio;

	import audio_format_pkg::*;
	import audio_control_pkg::*;

	// Clock half period, drive and sample offsets after the rising edge
	localparam int CLK_HALF     = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int SAMPLE_DELAY = 5;
	// Extra cycles a wait may spend past its latency
	localparam int SETTLE_LIMIT = 16;
	localparam int HOLD_CYCLES  = 3;

	logic                clk_chipset;
	logic                reset_wire;
	logic [OPL_W-1:0]    opl_sample_in;
	logic [TANDY_W-1:0]  tandy_sample_in;
	logic [VOLUME_W-1:0] tandy_volume;
	logic                speaker_bit;
	logic [VOLUME_W-1:0] speaker_volume;
	logic [BOOST_W-1:0]  boost_mode;
	logic [SAMPLE_W-1:0] audio_left;
	logic [SAMPLE_W-1:0] audio_right;

	// Output just before the newest drive
	logic [SAMPLE_W-1:0] prior_output;
	logic [31:0]         lcg_state;
	int                  check_count;
	int                  mismatch_count;
	int                  timeout_count;

	pcxt_audio_top u_pcxt_audio_top (
		.clk_chipset     (clk_chipset),
		.reset_wire      (reset_wire),
		.opl_sample_in   (opl_sample_in),
		.tandy_sample_in (tandy_sample_in),
		.tandy_volume    (tandy_volume),
		.speaker_bit     (speaker_bit),
		.speaker_volume  (speaker_volume),
		.boost_mode      (boost_mode),
		.audio_left      (audio_left),
		.audio_right     (audio_right)
	);

	// 20 ns period
	always #(CLK_HALF) clk_chipset = ~clk_chipset;

	//////////////////////////////////////////////////////////////////////
	// Random numbers and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper half, the low LCG bits repeat quickly
	function automatic logic [15:0] random_word();
		logic [31:0] word;
		word = lcg_next();
		return word[31:16];
	endfunction

	// Mix of the three sources, 17-bit sum then full-scale clamp
	function automatic logic [SAMPLE_W-1:0] mix_model(
		input logic [OPL_W-1:0]    opl,
		input logic [TANDY_W-1:0]  tandy,
		input logic [VOLUME_W-1:0] tvol,
		input logic                spk_bit,
		input logic [VOLUME_W-1:0] svol
	);
		logic [15:0] tandy_word;
		logic [16:0] guard_sum;
		int          sum;
		// Shift within 16 bits, bit 15 then read as sign
		tandy_word = 16'(tandy) << tvol;
		sum = int'($signed(opl)) + int'($signed(tandy_word));
		if (!spk_bit) begin
			sum = sum + ((1 << SPEAKER_FRAC_W) << svol);
		end
		guard_sum = sum[16:0];
		if (guard_sum[16] != guard_sum[15]) begin
			return guard_sum[16] ? 16'h8000 : 16'h7FFF;
		end
		return guard_sum[15:0];
	endfunction

	// 32767 * (f-1) / (f*a-1), plus one
	function automatic int curve_threshold(input int ratio, input int gain);
		return (((1 << (SAMPLE_W - 1)) - 1) * (ratio - 1)) / (ratio * gain - 1) + 1;
	endfunction

	function automatic logic [SAMPLE_W-1:0] curve_model(
		input logic [SAMPLE_W-1:0] sample,
		input int                  ratio,
		input int                  gain
	);
		int thresh;
		int mag;
		int result;
		thresh = curve_threshold(ratio, gain);
		mag = $signed(sample);
		if (mag < 0) begin
			mag = -mag;
		end
		// Gain below the threshold, compressed slope from the knee up
		if (mag < thresh) begin
			result = mag * gain;
		end else begin
			result = (mag - thresh) / ratio + thresh * gain;
		end
		if (sample[SAMPLE_W-1]) begin
			result = -result;
		end
		return result[SAMPLE_W-1:0];
	endfunction

	// Expected output for the inputs now driven
	function automatic logic [SAMPLE_W-1:0] current_expected();
		logic [SAMPLE_W-1:0] mix;
		mix = mix_model(opl_sample_in, tandy_sample_in, tandy_volume, speaker_bit,
			speaker_volume);
		if (boost_mode == BOOST_OFF) begin
			return mix;
		end else if (boost_mode == BOOST_2X) begin
			return curve_model(mix, LOW_RATIO, LOW_GAIN);
		end
		// Codes 2 and 3
		return curve_model(mix, HIGH_RATIO, HIGH_GAIN);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks and waits
	//////////////////////////////////////////////////////////////////////

	task automatic check_sample(
		input logic [SAMPLE_W-1:0] actual,
		input logic [SAMPLE_W-1:0] expected,
		input string               what
	);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, got %0d expected %0d", $time, what,
				$signed(actual), $signed(expected));
		end
	endtask

	task automatic check_pair(input logic [SAMPLE_W-1:0] left, input logic [SAMPLE_W-1:0] right);
		check_count++;
		if (left !== right) begin
			mismatch_count++;
			$display("Mismatch at %0t: left %0d and right %0d differ", $time,
				$signed(left), $signed(right));
		end
	endtask

	task automatic check_latency(input int actual, input int expected, input string what);
		check_count++;
		if (actual != expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: %s, latency %0d cycles, expected %0d", $time, what,
				actual, expected);
		end
	endtask

	// Next drive point, remembers the output before the change
	task automatic drive_slot();
		@(posedge clk_chipset);
		#1;
		prior_output = audio_left;
		#(DRIVE_DELAY - 1);
	endtask

	task automatic hold_output(
		input logic [SAMPLE_W-1:0] expected,
		input int                  cycles,
		input string               what
	);
		int cycle;
		for (cycle = 0; cycle < cycles; cycle++) begin
			@(posedge clk_chipset);
			#SAMPLE_DELAY;
			check_sample(audio_left, expected, what);
			check_pair(audio_left, audio_right);
		end
	endtask

	// Latency 0 waits for the value without timing it
	task automatic await_output(
		input logic [SAMPLE_W-1:0] expected,
		input int                  latency,
		input string               what
	);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < latency + SETTLE_LIMIT) begin
			@(posedge clk_chipset);
			#SAMPLE_DELAY;
			cycles++;
			check_pair(audio_left, audio_right);
			seen = (audio_left === expected);
		end
		if (!seen) begin
			timeout_count++;
			$display("Timeout: %s did not reach %0d within %0d cycles", what,
				$signed(expected), cycles);
		end else begin
			// An unchanged output carries no latency
			if (latency > 0 && prior_output !== expected) begin
				check_latency(cycles, latency, what);
			end
			hold_output(expected, HOLD_CYCLES, what);
		end
	endtask

	`include "tb_pcxt_audio_tests.svh"

	initial begin
		lcg_state       = 32'd78987;
		clk_chipset     = 1'b0;
		reset_wire      = 1'b1;
		opl_sample_in   = '0;
		tandy_sample_in = '0;
		tandy_volume    = '0;
		speaker_bit     = 1'b1;
		speaker_volume  = '0;
		boost_mode      = BOOST_OFF;
		prior_output    = '0;
		check_count     = 0;
		mismatch_count  = 0;
		timeout_count   = 0;
		reset_state_test();
		stability_filter_test();
		volume_sum_test();
		saturation_test();
		compressor_curve_test();
		$display("checks %0d, mismatches %0d, timeouts %0d", check_count, mismatch_count,
			timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog/pcxt_audio_top.sv ====
// Audio path top level: source capture, mix and compressor, driving mono to both channels
`timescale 1ns/1ps

module pcxt_audio_top #(
	// Compressor curves, passed straight down
	parameter int unsigned LOW_RATIO  = audio_control_pkg::LOW_RATIO,
	parameter int unsigned LOW_GAIN   = audio_control_pkg::LOW_GAIN,
	parameter int unsigned HIGH_RATIO = audio_control_pkg::HIGH_RATIO,
	parameter int unsigned HIGH_GAIN  = audio_control_pkg::HIGH_GAIN
) (
	input  logic                                     clk_chipset,
	input  logic                                     reset_wire,

	// Sound sources
	input  logic [audio_format_pkg::OPL_W-1:0]       opl_sample_in,
	input  logic [audio_format_pkg::TANDY_W-1:0]     tandy_sample_in,
	input  logic [audio_control_pkg::VOLUME_W-1:0]   tandy_volume,
	input  logic                                     speaker_bit,
	input  logic [audio_control_pkg::VOLUME_W-1:0]   speaker_volume,

	// Compressor control
	input  logic [audio_control_pkg::BOOST_W-1:0]    boost_mode,

	// Mono result on both channels
	output logic [audio_format_pkg::SAMPLE_W-1:0]    audio_left,
	output logic [audio_format_pkg::SAMPLE_W-1:0]    audio_right
);

	import audio_format_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Stage links
	//////////////////////////////////////////////////////////////////////

	logic [MIX_W-1:0]    opl_level;
	logic [MIX_W-1:0]    tandy_level;
	logic [MIX_W-1:0]    speaker_level;
	logic [SAMPLE_W-1:0] mix_sample;
	logic [SAMPLE_W-1:0] audio_sample;

	// Stable capture and volume scaling
	audio_source_sync u_audio_source_sync (
		.clk_chipset     (clk_chipset),
		.reset_wire      (reset_wire),
		.opl_sample_in   (opl_sample_in),
		.tandy_sample_in (tandy_sample_in),
		.tandy_volume    (tandy_volume),
		.speaker_bit     (speaker_bit),
		.speaker_volume  (speaker_volume),
		.opl_level       (opl_level),
		.tandy_level     (tandy_level),
		.speaker_level   (speaker_level)
	);

	// Sum and clamp
	audio_mix_stage u_audio_mix_stage (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.opl_level     (opl_level),
		.tandy_level   (tandy_level),
		.speaker_level (speaker_level),
		.mix_sample    (mix_sample)
	);

	// Boost curve or bypass
	audio_compressor #(
		.LOW_RATIO  (LOW_RATIO),
		.LOW_GAIN   (LOW_GAIN),
		.HIGH_RATIO (HIGH_RATIO),
		.HIGH_GAIN  (HIGH_GAIN)
	) u_audio_compressor (
		.clk_chipset  (clk_chipset),
		.reset_wire   (reset_wire),
		.mix_sample   (mix_sample),
		.boost_mode   (boost_mode),
		.audio_sample (audio_sample)
	);

	// Same sample left and right
	assign audio_left  = audio_sample;
	assign audio_right = audio_sample;

endmodule

// ==== verilog/audio_compressor.sv ====
// Dynamic range compressor that applies the selected boost curve to the mix or bypasses it
`timescale 1ns/1ps

module audio_compressor #(
	// Low curve ratio above the knee and gain below it
	parameter int unsigned LOW_RATIO  = audio_control_pkg::LOW_RATIO,
	parameter int unsigned LOW_GAIN   = audio_control_pkg::LOW_GAIN,
	// High curve
	parameter int unsigned HIGH_RATIO = audio_control_pkg::HIGH_RATIO,
	parameter int unsigned HIGH_GAIN  = audio_control_pkg::HIGH_GAIN
) (
	input  logic                                     clk_chipset,
	input  logic                                     reset_wire,

	// Clamped mix from the mix stage
	input  logic [audio_format_pkg::SAMPLE_W-1:0]    mix_sample,

	// Curve select with bypass at BOOST_OFF
	input  logic [audio_control_pkg::BOOST_W-1:0]    boost_mode,

	output logic [audio_format_pkg::SAMPLE_W-1:0]    audio_sample
);

	import audio_format_pkg::*;
	import audio_control_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Curve constants
	//////////////////////////////////////////////////////////////////////

	// Largest positive sample
	localparam int unsigned FULL_SCALE = (2 ** (SAMPLE_W - 1)) - 1;

	// Input level where the gain segment hands over to the compressed slope
	localparam int unsigned LOW_THRESH =
		((FULL_SCALE * (LOW_RATIO - 1)) / ((LOW_RATIO * LOW_GAIN) - 1)) + 1;
	localparam int unsigned HIGH_THRESH =
		((FULL_SCALE * (HIGH_RATIO - 1)) / ((HIGH_RATIO * HIGH_GAIN) - 1)) + 1;

	// Output level at the threshold
	localparam int unsigned LOW_KNEE  = LOW_THRESH * LOW_GAIN;
	localparam int unsigned HIGH_KNEE = HIGH_THRESH * HIGH_GAIN;

	//////////////////////////////////////////////////////////////////////
	// Curve function
	//////////////////////////////////////////////////////////////////////

	// Curve on the magnitude with the sign put back at the end
	function automatic logic [SAMPLE_W-1:0] curve_value(
		input logic [SAMPLE_W-1:0] sample,
		input int unsigned         thresh,
		input int unsigned         knee,
		input int unsigned         ratio,
		input int unsigned         gain
	);
		logic [SAMPLE_W:0] mag;
		logic [31:0]       level;
		logic [31:0]       neg_level;
		// Extra bit so -32768 gets its true magnitude
		mag = sample[SAMPLE_W-1] ? ({1'b0, ~sample} + 1'b1) : {1'b0, sample};
		if (mag < thresh) begin
			// Linear gain below threshold
			level = mag * gain;
		end else begin
			// Compressed slope above it
			level = ((mag - thresh) / ratio) + knee;
		end
		neg_level = ~level + 32'd1;
		curve_value = sample[SAMPLE_W-1] ? neg_level[SAMPLE_W-1:0] : level[SAMPLE_W-1:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Curve evaluation and register
	//////////////////////////////////////////////////////////////////////

	logic [SAMPLE_W-1:0] low_value;
	logic [SAMPLE_W-1:0] high_value;
	logic                high_sel;
	logic [SAMPLE_W-1:0] curve_q;

	always_comb begin
		low_value  = curve_value(mix_sample, LOW_THRESH, LOW_KNEE, LOW_RATIO, LOW_GAIN);
		high_value = curve_value(mix_sample, HIGH_THRESH, HIGH_KNEE, HIGH_RATIO, HIGH_GAIN);
		// Codes 2 and 3 both pick the high curve
		high_sel   = (boost_mode >= BOOST_4X);
	end

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			curve_q <= '0;
		end else begin
			curve_q <= high_sel ? high_value : low_value;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output select
	//////////////////////////////////////////////////////////////////////

	// Bypass skips the curve register entirely
	always_comb begin
		if (boost_mode == BOOST_OFF) begin
			audio_sample = mix_sample;
		end else begin
			audio_sample = curve_q;
		end
	end

endmodule

// ==== verilog/audio_mix_stage.sv ====
// Mix stage: sums the three source levels and saturates the result to one sample word
`timescale 1ns/1ps

module audio_mix_stage (
	input  logic                                   clk_chipset,
	input  logic                                   reset_wire,

	// Source levels, already sign extended to guard width
	input  logic [audio_format_pkg::MIX_W-1:0]     opl_level,
	input  logic [audio_format_pkg::MIX_W-1:0]     tandy_level,
	input  logic [audio_format_pkg::MIX_W-1:0]     speaker_level,

	// Clamped mono mix
	output logic [audio_format_pkg::SAMPLE_W-1:0]  mix_sample
);

	import audio_format_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Sum register
	//////////////////////////////////////////////////////////////////////

	// Three-way sum at guard width
	logic [MIX_W-1:0] sum_q;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sum_q <= '0;
		end else begin
			sum_q <= opl_level + tandy_level + speaker_level;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Saturation
	//////////////////////////////////////////////////////////////////////

	logic                overflow;
	logic [SAMPLE_W-1:0] clamped;

	always_comb begin
		// Guard bit and sample sign disagree on overflow
		overflow = sum_q[MIX_W-1] ^ sum_q[MIX_W-2];
		if (overflow) begin
			// Full scale, direction from the guard bit
			clamped = {sum_q[MIX_W-1], {(SAMPLE_W-1){~sum_q[MIX_W-1]}}};
		end else begin
			clamped = sum_q[SAMPLE_W-1:0];
		end
	end

	// Output register
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			mix_sample <= '0;
		end else begin
			mix_sample <= clamped;
		end
	end

endmodule

// ==== verilog/audio_source_sync.sv ====
// Source capture stage that filters FM and Tandy samples for stability and forms source levels
`timescale 1ns/1ps

module audio_source_sync (
	input  logic                                      clk_chipset,
	input  logic                                      reset_wire,

	// FM sample that may change at any time
	input  logic [audio_format_pkg::OPL_W-1:0]        opl_sample_in,

	// Tandy sample and its volume shift
	input  logic [audio_format_pkg::TANDY_W-1:0]      tandy_sample_in,
	input  logic [audio_control_pkg::VOLUME_W-1:0]    tandy_volume,

	// PC speaker that sounds when low
	input  logic                                      speaker_bit,
	input  logic [audio_control_pkg::VOLUME_W-1:0]    speaker_volume,

	// Levels to the mix stage at guard width
	output logic [audio_format_pkg::MIX_W-1:0]        opl_level,
	output logic [audio_format_pkg::MIX_W-1:0]        tandy_level,
	output logic [audio_format_pkg::MIX_W-1:0]        speaker_level
);

	import audio_format_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////////////////////////

	// Zero pad that lifts the Tandy sample to a full sample word
	localparam int TANDY_PAD_W = SAMPLE_W - TANDY_W;

	// Speaker field between 2 top zero bits and the fraction zeros
	localparam int SPK_FIELD_W = MIX_W - SPEAKER_FRAC_W - 2;

	//////////////////////////////////////////////////////////////////////
	// Volume scaling ahead of capture
	//////////////////////////////////////////////////////////////////////

	logic [SAMPLE_W-1:0]    tandy_scaled;
	logic [SPK_FIELD_W-1:0] spk_field;

	always_comb begin
		// Shift inside 16 bits so upper bits fall off
		tandy_scaled = {{TANDY_PAD_W{1'b0}}, tandy_sample_in} << tandy_volume;
		// Single pulse bit walks up with the volume
		spk_field = {{(SPK_FIELD_W-1){1'b0}}, ~speaker_bit} << speaker_volume;
	end

	//////////////////////////////////////////////////////////////////////
	// FM capture
	//////////////////////////////////////////////////////////////////////

	// Two-deep capture with the newest first
	logic [OPL_W-1:0] opl_cap0;
	logic [OPL_W-1:0] opl_cap1;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			opl_cap0  <= '0;
			opl_cap1  <= '0;
			opl_level <= '0;
		end else begin
			opl_cap0 <= opl_sample_in;
			opl_cap1 <= opl_cap0;
			// Only take a value seen on two reads in a row
			if (opl_cap0 == opl_cap1) begin
				opl_level <= {{(MIX_W-OPL_W){opl_cap1[OPL_W-1]}}, opl_cap1};
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tandy capture
	//////////////////////////////////////////////////////////////////////

	// Captures the already scaled value
	logic [SAMPLE_W-1:0] tandy_cap0;
	logic [SAMPLE_W-1:0] tandy_cap1;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_cap0  <= '0;
			tandy_cap1  <= '0;
			tandy_level <= '0;
		end else begin
			tandy_cap0 <= tandy_scaled;
			tandy_cap1 <= tandy_cap0;
			// Bit 15 is treated as sign after the shift
			if (tandy_cap0 == tandy_cap1) begin
				tandy_level <= {{(MIX_W-SAMPLE_W){tandy_cap1[SAMPLE_W-1]}}, tandy_cap1};
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Speaker level
	//////////////////////////////////////////////////////////////////////

	// Single register without a stability filter
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			speaker_level <= '0;
		end else begin
			speaker_level <= {2'b00, spk_field, {SPEAKER_FRAC_W{1'b0}}};
		end
	end

endmodule

// ==== verilog/audio_control_pkg.sv ====
// User control field widths, boost codes and default curve constants for the audio path

package audio_control_pkg;

	//////////////////////////////////////////////////////////////////////
	// Control field widths
	//////////////////////////////////////////////////////////////////////

	// Tandy and speaker volume, as a left shift amount
	localparam int VOLUME_W = 2;

	// Boost selector
	localparam int BOOST_W = 2;

	//////////////////////////////////////////////////////////////////////
	// Boost codes
	//////////////////////////////////////////////////////////////////////

	// Mix goes straight to the output
	localparam logic [BOOST_W-1:0] BOOST_OFF = 2'd0;
	// Low curve
	localparam logic [BOOST_W-1:0] BOOST_2X = 2'd1;
	// High curve, code 3 lands here too
	localparam logic [BOOST_W-1:0] BOOST_4X = 2'd2;

	//////////////////////////////////////////////////////////////////////
	// Default compressor curves
	//////////////////////////////////////////////////////////////////////

	// 2x boost, 4:1 above the knee
	localparam int unsigned LOW_RATIO = 4;
	localparam int unsigned LOW_GAIN = 2;

	// 4x boost, 8:1 above the knee
	localparam int unsigned HIGH_RATIO = 8;
	localparam int unsigned HIGH_GAIN = 4;

endpackage

// ==== verilog/audio_format_pkg.sv ====
// Sample and mix width constants, imported by the audio RTL and its testbench

package audio_format_pkg;

	//////////////////////////////////////////////////////////////////////
	// Source sample widths
	//////////////////////////////////////////////////////////////////////

	// FM (OPL2) sample, two's complement
	localparam int OPL_W = 16;

	// Tandy PSG sample, unsigned
	localparam int TANDY_W = 14;

	//////////////////////////////////////////////////////////////////////
	// Datapath widths
	//////////////////////////////////////////////////////////////////////

	// Output sample and per-source level, signed
	localparam int SAMPLE_W = 16;

	// Sum width, one guard bit for overflow detect
	localparam int MIX_W = SAMPLE_W + 1;

	// Speaker pulse sits above this many zero bits
	localparam int SPEAKER_FRAC_W = 11;

endpackage
